// ==== project.f ====
+incdir+include
hdl/lc3b_types.sv
hdl/branch_pkg.sv
hdl/btb_fetch_stage.sv
hdl/inflight_fifo.sv
hdl/branch_resolve_ctrl.sv
hdl/branch_unit_top.sv
tb/branch_unit_sva.sv
tb/tb_branch_unit.sv

// ==== Makefile ====
TOP := tb_branch_unit

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f project.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee sim.log
	grep -q "^No errors$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tb/tb_branch_unit.sv ====
module tb_branch_unit
	import lc3b_types::*;
	import branch_pkg::*;
();

	localparam int WAIT_LIMIT = 200;

	typedef struct packed {
		fetch_in_t stim;
		result_t exp;
	} case_t;

	logic clk;
	logic rst_n;
	logic in_valid;
	logic in_ready;
	fetch_in_t in_rec;
	logic out_valid;
	logic out_ready;
	result_t out_res;

	case_t cases[$];
	int errors = 0;
	bit abort = 1'b0;

	branch_unit_top u_dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_rec    (in_rec),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_res   (out_res)
	);

	bind branch_unit_top branch_unit_sva u_sva (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_rec    (in_rec),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_res   (out_res),
		.btb_upd   (btb_upd)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// random back-pressure on the result port
	initial begin
		out_ready = 1'b0;
		void'($urandom(34923));
		forever begin
			@(posedge clk);
			out_ready <= (($urandom % 4) != 0);
		end
	end

	task automatic check_outcome(input bp_outcome_e got, input bp_outcome_e exp, input int idx);
		if (got !== exp) begin
			$display("ERROR %0t: record %0d outcome is %s, expected %s",
				$time, idx, got.name(), exp.name());
			errors++;
		end
	endtask

	task automatic check_word(input lc3b_word got, input lc3b_word exp, input string what,
		input int idx);
		if (got !== exp) begin
			$display("ERROR %0t: record %0d %s is %h, expected %h", $time, idx, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what, input int idx);
		if (got !== exp) begin
			$display("ERROR %0t: record %0d %s is %b, expected %b", $time, idx, what, got, exp);
			errors++;
		end
	endtask

	task automatic load_case(input lc3b_word pc, input lc3b_word instr, input lc3b_word base,
		input lc3b_nzp cc, input lc3b_opcode op, input logic taken, input lc3b_word target,
		input bp_outcome_e outcome);
		case_t c;
		c.stim.pc = pc;
		c.stim.instruction = instr;
		c.stim.base = base;
		c.stim.cc = cc;
		c.exp.pc = pc;
		c.exp.opcode = op;
		c.exp.act_taken = taken;
		c.exp.act_target = target;
		c.exp.outcome = outcome;
		cases.push_back(c);
	endtask

	// wrong-path ADD that falls inside a flush window
	task automatic pad_squashed(input lc3b_word pc);
		load_case(pc, 16'h1000, 16'h0000, 3'b000, op_add, 1'b0, pc + 16'h0002, out_squashed);
	endtask

	task automatic build_table();
		// cold BTB, every taken transfer misses on direction
		load_case(16'h3000, 16'h0405, 16'h0000, 3'b010, op_br, 1'b1, 16'h300C, out_dir_miss);
		pad_squashed(16'h3002);
		pad_squashed(16'h3004);
		pad_squashed(16'h3006);
		load_case(16'h3022, 16'hC080, 16'h4000, 3'b000, op_jmp, 1'b1, 16'h4000, out_dir_miss);
		pad_squashed(16'h3024);
		load_case(16'h3026, 16'h0E02, 16'h0000, 3'b001, op_br, 1'b1, 16'h302C, out_squashed);
		pad_squashed(16'h3028);
		load_case(16'h3034, 16'h4810, 16'h0000, 3'b000, op_jsr, 1'b1, 16'h3056, out_dir_miss);
		pad_squashed(16'h3036);
		pad_squashed(16'h3038);
		pad_squashed(16'h303A);
		// JSRR through base
		load_case(16'h3046, 16'h40C0, 16'h5000, 3'b000, op_jsr, 1'b1, 16'h5000, out_dir_miss);
		pad_squashed(16'h3048);
		pad_squashed(16'h304A);
		pad_squashed(16'h304C);
		load_case(16'h3058, 16'hF025, 16'h0000, 3'b000, op_trap, 1'b1, 16'h004A, out_dir_miss);
		pad_squashed(16'h305A);
		pad_squashed(16'h305C);
		pad_squashed(16'h305E);
		// trained entries
		load_case(16'h3000, 16'h0405, 16'h0000, 3'b010, op_br, 1'b1, 16'h300C, out_correct);
		load_case(16'h3022, 16'hC080, 16'h4100, 3'b000, op_jmp, 1'b1, 16'h4100, out_target_miss);
		pad_squashed(16'h3024);
		pad_squashed(16'h3026);
		pad_squashed(16'h3028);
		// condition now fails, entry gets cleared
		load_case(16'h3000, 16'h0405, 16'h0000, 3'b001, op_br, 1'b0, 16'h3002, out_dir_miss);
		pad_squashed(16'h3002);
		pad_squashed(16'h3004);
		pad_squashed(16'h3006);
		load_case(16'h3000, 16'h0405, 16'h0000, 3'b001, op_br, 1'b0, 16'h3002, out_correct);
		load_case(16'h3070, 16'h0000, 16'h0000, 3'b111, op_br, 1'b0, 16'h3072, out_correct);
		load_case(16'h3072, 16'h1234, 16'h0000, 3'b000, op_add, 1'b0, 16'h3074, out_correct);
		load_case(16'h3074, 16'h5020, 16'h0000, 3'b000, op_and, 1'b0, 16'h3076, out_correct);
		load_case(16'h3076, 16'hE005, 16'h0000, 3'b000, op_lea, 1'b0, 16'h3078, out_correct);
		load_case(16'h3022, 16'hC080, 16'h4100, 3'b000, op_jmp, 1'b1, 16'h4100, out_correct);
		load_case(16'h3058, 16'hF025, 16'h0000, 3'b000, op_trap, 1'b1, 16'h004A, out_correct);
		load_case(16'h3034, 16'h4810, 16'h0000, 3'b000, op_jsr, 1'b1, 16'h3056, out_correct);
	endtask

	task automatic send_records();
		int waited;
		foreach (cases[i]) begin
			if (abort) begin
				break;
			end
			in_valid <= 1'b1;
			in_rec <= cases[i].stim;
			waited = 0;
			@(negedge clk);
			while (!in_ready && waited < WAIT_LIMIT) begin
				@(negedge clk);
				waited++;
			end
			if (!in_ready) begin
				$display("timeout: input record %0d was never accepted", i);
				errors++;
				abort = 1'b1;
			end
			@(posedge clk);
		end
		in_valid <= 1'b0;
	endtask

	task automatic collect_results();
		int waited;
		result_t got;
		foreach (cases[i]) begin
			waited = 0;
			@(negedge clk);
			while (!(out_valid && out_ready) && waited < WAIT_LIMIT && !abort) begin
				@(negedge clk);
				waited++;
			end
			if (!(out_valid && out_ready)) begin
				$display("timeout: result %0d never came out of the DUT", i);
				errors++;
				abort = 1'b1;
				break;
			end
			got = out_res;
			check_word(got.pc, cases[i].exp.pc, "pc", i);
			check_word(lc3b_word'(got.opcode), lc3b_word'(cases[i].exp.opcode), "opcode", i);
			check_bit(got.act_taken, cases[i].exp.act_taken, "act_taken", i);
			check_word(got.act_target, cases[i].exp.act_target, "act_target", i);
			check_outcome(got.outcome, cases[i].exp.outcome, i);
		end
	endtask

	initial begin
		int total;
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_rec = '0;
		build_table();
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		fork
			send_records();
			collect_results();
		join
		// let the last transfer reach the assertions
		repeat (2) @(posedge clk);
		total = errors + int'(u_dut.u_sva.fail_count);
		$display("%0d records, %0d check errors, %0d assertion failures",
			cases.size(), errors, u_dut.u_sva.fail_count);
		if (total == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule : tb_branch_unit

// ==== tb/branch_unit_sva.sv ====
`include "bp_consts.svh"

module branch_unit_sva
	import branch_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input logic in_ready,
	input fetch_in_t in_rec,
	input logic out_valid,
	input logic out_ready,
	input result_t out_res,
	input btb_update_t btb_upd
);

	localparam int CNT_W = $clog2(`FLUSH_LEN + 1);

	int unsigned fail_count = 0;
	logic [CNT_W-1:0] squash_left;
	logic out_xfer;
	logic graded_miss;

	assign out_xfer = out_valid && out_ready;
	assign graded_miss = (out_res.outcome == out_dir_miss) || (out_res.outcome == out_target_miss);

	// squashed transfers still owed after the last graded miss
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			squash_left <= '0;
		end else if (out_xfer) begin
			if (squash_left != '0) begin
				squash_left <= squash_left - 1'b1;
			end else if (graded_miss) begin
				squash_left <= CNT_W'(`FLUSH_LEN);
			end
		end
	end

	in_hold: assert property (@(posedge clk) disable iff (!rst_n)
		in_valid && !in_ready |=> in_valid && $stable(in_rec))
		else begin
			fail_count++;
			$error("input record changed while stalled");
		end

	out_hold: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_res))
		else begin
			fail_count++;
			$error("result changed while stalled");
		end

	// only a graded miss trains the BTB, one operation at a time
	upd_on_miss: assert property (@(posedge clk) disable iff (!rst_n)
		btb_upd.write_en || btb_upd.clear_en |->
			(btb_upd.write_en != btb_upd.clear_en) && out_xfer && graded_miss
			&& (squash_left == '0))
		else begin
			fail_count++;
			$error("BTB update outside a graded miss or with write and clear together");
		end

	// exactly FLUSH_LEN squashed transfers between a miss and the next graded one
	flush_len: assert property (@(posedge clk) disable iff (!rst_n)
		out_xfer |-> ((squash_left != '0) == (out_res.outcome == out_squashed)))
		else begin
			fail_count++;
			$error("flush window has the wrong length");
		end

endmodule : branch_unit_sva

// ==== hdl/branch_unit_top.sv ====
`include "bp_consts.svh"

module branch_unit_top
	import branch_pkg::*;
(
	input logic clk,
	input logic rst_n,

	input logic in_valid,
	output logic in_ready,
	input fetch_in_t in_rec,

	output logic out_valid,
	input logic out_ready,
	output result_t out_res
);

	fetch_rec_t fetch_rec;
	logic fetch_valid;
	logic fetch_ready;

	fetch_rec_t head_rec;
	logic head_valid;
	logic head_ready;

	btb_update_t btb_upd;

	btb_fetch_stage u_fetch (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_rec    (in_rec),
		.out_valid (fetch_valid),
		.out_ready (fetch_ready),
		.out_rec   (fetch_rec),
		.btb_upd   (btb_upd)
	);

	// fetch register plus fifo never hold more than the flush window
	inflight_fifo #(
		.DEPTH (`FLUSH_LEN - 1)
	) u_fifo (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (fetch_valid),
		.in_ready  (fetch_ready),
		.in_data   (fetch_rec),
		.out_valid (head_valid),
		.out_ready (head_ready),
		.out_data  (head_rec)
	);

	branch_resolve_ctrl u_resolve (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (head_valid),
		.in_ready  (head_ready),
		.in_rec    (head_rec),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_res   (out_res),
		.btb_upd   (btb_upd)
	);

endmodule : branch_unit_top

// ==== hdl/branch_resolve_ctrl.sv ====
`include "bp_consts.svh"

module branch_resolve_ctrl
	import lc3b_types::*;
	import branch_pkg::*;
(
	input logic clk,
	input logic rst_n,

	input logic in_valid,
	output logic in_ready,
	input fetch_rec_t in_rec,

	output logic out_valid,
	input logic out_ready,
	output result_t out_res,

	output btb_update_t btb_upd
);

	resolve_state_e state;
	resolve_state_e next_state;

	lc3b_word instr;
	lc3b_opcode opcode;
	lc3b_word pc_next;
	lc3b_offset9 off9;
	lc3b_offset11 off11;
	lc3b_trapvect8 trapvect;
	lc3b_word br_target;
	lc3b_word jsr_target;
	lc3b_word trap_target;

	logic act_taken;
	lc3b_word act_target;
	bp_outcome_e graded;
	logic miss;
	logic squashing;
	logic xfer;

	assign instr = in_rec.fetch.instruction;
	assign opcode = lc3b_opcode'(instr[15:12]);
	assign off9 = instr[8:0];
	assign off11 = instr[10:0];
	assign trapvect = instr[7:0];

	assign pc_next = in_rec.fetch.pc + lc3b_word'(2);
	assign br_target = pc_next + {{(`WORD_W-10){off9[8]}}, off9, 1'b0};
	assign jsr_target = pc_next + {{(`WORD_W-12){off11[10]}}, off11, 1'b0};
	assign trap_target = {{(`WORD_W-9){1'b0}}, trapvect, 1'b0};

	// actual control transfer
	always_comb begin
		act_taken = 1'b0;
		act_target = pc_next;
		case (opcode)
			op_br: begin
				if (|(instr[11:9] & in_rec.fetch.cc)) begin
					act_taken = 1'b1;
					act_target = br_target;
				end
			end
			op_jmp: begin
				act_taken = 1'b1;
				act_target = in_rec.fetch.base;
			end
			op_jsr: begin
				act_taken = 1'b1;
				// bit 11 clear means JSRR
				act_target = instr[11] ? jsr_target : in_rec.fetch.base;
			end
			op_trap: begin
				act_taken = 1'b1;
				act_target = trap_target;
			end
			default: ;
		endcase
	end

	always_comb begin
		if (in_rec.pred_taken != act_taken) begin
			graded = out_dir_miss;
		end else if (act_taken && in_rec.pred_target != act_target) begin
			graded = out_target_miss;
		end else begin
			graded = out_correct;
		end
	end

	assign miss = (graded != out_correct);
	assign squashing = (state != s_detect);

	// head passes straight through, back-pressure stalls the FSM
	assign out_valid = in_valid;
	assign in_ready = out_ready;
	assign xfer = in_valid && out_ready;

	always_comb begin
		out_res.pc = in_rec.fetch.pc;
		out_res.opcode = opcode;
		out_res.act_taken = act_taken;
		out_res.act_target = act_target;
		out_res.outcome = squashing ? out_squashed : graded;
	end

	// wrong-path records never train the BTB
	always_comb begin
		btb_upd.write_en = xfer && !squashing && miss && act_taken;
		btb_upd.clear_en = xfer && !squashing && (graded == out_dir_miss) && !act_taken;
		btb_upd.pc = in_rec.fetch.pc;
		btb_upd.target = act_target;
	end

	always_comb begin
		next_state = state;
		if (xfer) begin
			case (state)
				s_detect: begin
					if (miss) begin
						next_state = s_flush_1;
					end
				end
				s_flush_1: next_state = s_flush_2;
				s_flush_2: next_state = s_flush_3;
				s_flush_3: next_state = s_detect;
				default: next_state = s_detect;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= s_detect;
		end else begin
			state <= next_state;
		end
	end

endmodule : branch_resolve_ctrl

// ==== hdl/inflight_fifo.sv ====
module inflight_fifo
	import branch_pkg::*;
#(
	parameter int DEPTH = 2
)
(
	input logic clk,
	input logic rst_n,

	input logic in_valid,
	output logic in_ready,
	input fetch_rec_t in_data,

	output logic out_valid,
	input logic out_ready,
	output fetch_rec_t out_data
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	fetch_rec_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic push;
	logic pop;

	assign out_valid = (count != '0);
	assign out_data = mem[rd_ptr];

	// a full buffer still takes a new record when the head leaves
	assign in_ready = (count != CNT_W'(DEPTH)) || out_ready;

	assign push = in_valid && in_ready;
	assign pop = out_valid && out_ready;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			if (push && !pop) begin
				count <= count + 1'b1;
			end else if (pop && !push) begin
				count <= count - 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= in_data;
		end
	end

endmodule : inflight_fifo

// ==== hdl/btb_fetch_stage.sv ====
`include "bp_consts.svh"

module btb_fetch_stage
	import lc3b_types::*;
	import branch_pkg::*;
(
	input logic clk,
	input logic rst_n,

	input logic in_valid,
	output logic in_ready,
	input fetch_in_t in_rec,

	output logic out_valid,
	input logic out_ready,
	output fetch_rec_t out_rec,

	input btb_update_t btb_upd
);

	localparam int IDX_W = $clog2(`BTB_ENTRIES);
	localparam int TAG_W = `WORD_W - IDX_W - 1;

	logic [`BTB_ENTRIES-1:0] btb_valid;
	logic [TAG_W-1:0] btb_tag [`BTB_ENTRIES];
	lc3b_word btb_target [`BTB_ENTRIES];

	logic [IDX_W-1:0] lk_idx;
	logic [TAG_W-1:0] lk_tag;
	logic [IDX_W-1:0] upd_idx;
	logic [TAG_W-1:0] upd_tag;

	logic hit_valid;
	logic [TAG_W-1:0] hit_tag;
	lc3b_word hit_target;
	logic pred_taken;
	lc3b_word pred_target;
	logic accept;

	// bit 0 of pc is always zero, so skip it
	assign lk_idx = in_rec.pc[IDX_W:1];
	assign lk_tag = in_rec.pc[`WORD_W-1:IDX_W+1];
	assign upd_idx = btb_upd.pc[IDX_W:1];
	assign upd_tag = btb_upd.pc[`WORD_W-1:IDX_W+1];

	always_comb begin
		hit_valid = btb_valid[lk_idx];
		hit_tag = btb_tag[lk_idx];
		hit_target = btb_target[lk_idx];
		// update landing this edge wins over the stored entry
		if (btb_upd.write_en && upd_idx == lk_idx) begin
			hit_valid = 1'b1;
			hit_tag = upd_tag;
			hit_target = btb_upd.target;
		end else if (btb_upd.clear_en && upd_idx == lk_idx) begin
			hit_valid = 1'b0;
		end
		pred_taken = hit_valid && (hit_tag == lk_tag);
		pred_target = pred_taken ? hit_target : in_rec.pc + lc3b_word'(2);
	end

	assign in_ready = !out_valid || out_ready;
	assign accept = in_valid && in_ready;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else if (in_ready) begin
			out_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			out_rec.fetch <= in_rec;
			out_rec.pred_taken <= pred_taken;
			out_rec.pred_target <= pred_target;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			btb_valid <= '0;
		end else if (btb_upd.write_en) begin
			btb_valid[upd_idx] <= 1'b1;
		end else if (btb_upd.clear_en) begin
			btb_valid[upd_idx] <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (btb_upd.write_en) begin
			btb_tag[upd_idx] <= upd_tag;
			btb_target[upd_idx] <= btb_upd.target;
		end
	end

endmodule : btb_fetch_stage

// ==== hdl/branch_pkg.sv ====
package branch_pkg;

	import lc3b_types::*;

	// decoded instruction as it arrives from fetch
	typedef struct packed {
		lc3b_word pc;
		lc3b_word instruction;
		// register value for JMP and JSRR
		lc3b_word base;
		lc3b_nzp cc;
	} fetch_in_t;

	typedef struct packed {
		fetch_in_t fetch;
		logic pred_taken;
		lc3b_word pred_target;
	} fetch_rec_t;

	// one-cycle pulse back to the BTB
	typedef struct packed {
		logic write_en;
		logic clear_en;
		lc3b_word pc;
		lc3b_word target;
	} btb_update_t;

	typedef enum logic [1:0] {
		out_correct,
		out_dir_miss,
		out_target_miss,
		out_squashed
	} bp_outcome_e;

	typedef struct packed {
		lc3b_word pc;
		lc3b_opcode opcode;
		logic act_taken;
		lc3b_word act_target;
		bp_outcome_e outcome;
	} result_t;

	typedef enum logic [1:0] {
		s_detect,
		s_flush_1,
		s_flush_2,
		s_flush_3
	} resolve_state_e;

endpackage : branch_pkg

// ==== hdl/lc3b_types.sv ====
`include "bp_consts.svh"

package lc3b_types;

	typedef logic [`WORD_W-1:0] lc3b_word;

	// condition codes, n z p from msb down
	typedef logic [2:0] lc3b_nzp;

	typedef logic [8:0] lc3b_offset9;
	typedef logic [10:0] lc3b_offset11;
	typedef logic [7:0] lc3b_trapvect8;

	typedef enum logic [3:0] {
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_rti  = 4'b1000,
		op_not  = 4'b1001,
		op_ldi  = 4'b1010,
		op_sti  = 4'b1011,
		// also RET when base is r7
		op_jmp  = 4'b1100,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode;

endpackage : lc3b_types

// ==== include/bp_consts.svh ====
`ifndef BP_CONSTS_SVH
`define BP_CONSTS_SVH

// direct-mapped, indexed by pc[3:1]
`define BTB_ENTRIES 8

// records fetched down the wrong path after a miss
`define FLUSH_LEN 3

`define WORD_W 16

`endif
